//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mmu
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
source/sv32_pkg.sv
source/core_mem_pkg.sv
source/tlb_direct.sv
source/page_walker.sv
source/mmu.sv
source/phys_mem.sv
source/mmu_top.sv
sim/tb_mmu.sv

//--- sim/tb_mmu.sv
`timescale 1ns/1ps
//******************************
// tb_mmu
// directed tests for the Sv32 MMU, with page
// tables built through bare-mode stores
//******************************
module tb_mmu
    import sv32_pkg::*;
    import core_mem_pkg::*;
();
    // about 40 accesses of under 30 cycles each, with a wide margin
    localparam int          TIMEOUT_CYCLES = 20000;
    // paging on, root table at 0x1000
    localparam logic [31:0] SATP_ON = 32'h8000_0001;
    localparam logic [7:0]  FL_V = 8'h01;
    localparam logic [7:0]  FL_R = 8'h02;
    localparam logic [7:0]  FL_W = 8'h04;
    localparam logic [7:0]  FL_X = 8'h08;
    localparam logic [7:0]  FL_U = 8'h10;

    logic        CLK;
    logic        rst;
    mmu_req_t    req;
    logic        flush;
    logic [31:0] paddr;
    logic [31:0] rdata;
    logic        busy;
    cause_t      fault;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    // busy cycles seen by the last access
    int          busy_cycles = 0;

    mmu_top DUT (.CLK, .rst, .req, .flush, .paddr, .rdata, .busy, .fault);

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, an access never completed", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    // Sv32 PTE word with PPN in bits 29:10
    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {2'b00, ppn, 2'b00, flags};
    endfunction

    task automatic core_access(input priv_t priv, input access_t kind, input logic [31:0] vaddr,
                               input logic [31:0] wdata, input logic sum,
                               output logic [31:0] pa, output logic [31:0] rd,
                               output cause_t cause);
        @(posedge CLK);
        #1;
        req.insn_addr = vaddr;
        req.data_addr = vaddr;
        req.wdata     = wdata;
        req.data_we   = (kind == acc_write);
        req.size      = size_w;
        req.access    = kind;
        req.priv      = priv;
        req.satp      = SATP_ON;
        req.sum       = sum;
        req.mxr       = 1'b0;
        busy_cycles   = 0;
        // done in the first cycle with busy low
        @(negedge CLK);
        while (busy) begin
            busy_cycles++;
            @(negedge CLK);
        end
        pa    = paddr;
        rd    = rdata;
        cause = fault;
        @(posedge CLK);
        #1;
        req.access  = acc_none;
        req.data_we = 1'b0;
    endtask

    task automatic bare_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        core_access(priv_m, acc_write, addr, data, 1'b0, pa, rd, cause);
    endtask

    task automatic bare_load(input logic [31:0] addr, output logic [31:0] data);
        logic [31:0] pa;
        cause_t      cause;
        core_access(priv_m, acc_read, addr, 32'h0, 1'b0, pa, data, cause);
    endtask

    task automatic xlat_access(input access_t kind, input logic [31:0] vaddr,
                               input logic [31:0] wdata, input logic sum,
                               output logic [31:0] pa, output logic [31:0] rd,
                               output cause_t cause);
        core_access(priv_s, kind, vaddr, wdata, sum, pa, rd, cause);
    endtask

    task automatic pulse_flush();
        @(posedge CLK);
        #1;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
    endtask

    task automatic bare_roundtrip();
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        repeat (4) begin
            addr = ($urandom % 1024) * 4;
            word = $urandom;
            core_access(priv_m, acc_write, addr, word, 1'b0, pa, rd, cause);
            check_eq("paddr", pa, addr);
            // bare store never raises busy
            check_eq("busy", busy_cycles, 32'd0);
            core_access(priv_m, acc_read, addr, 32'h0, 1'b0, pa, rd, cause);
            check_eq("paddr", pa, addr);
            check_eq("rdata", rd, word);
        end
    endtask

    // level-1 entry 0 points to the level-0 table at 0x2000
    task automatic build_tables();
        bare_store(32'h1000, make_pte(20'h2, FL_V));
        bare_store(32'h1004, make_pte(20'h800, FL_V | FL_X));
        bare_store(32'h2014, make_pte(20'h3, FL_V | FL_R));
        bare_store(32'h2018, 32'h0);
        bare_store(32'h201C, make_pte(20'h3, FL_V | FL_R));
        bare_store(32'h2020, make_pte(20'h3, FL_V | FL_R | FL_U));
        bare_store(32'h2024, make_pte(20'h3, FL_V | FL_R));
        bare_store(32'h2028, make_pte(20'h3, FL_V | FL_R | FL_W));
        bare_store(32'h202C, make_pte(20'h3, FL_V | FL_R));
    endtask

    task automatic small_page_load();
        logic [31:0] off;
        logic [31:0] word;
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        off  = ($urandom % 256) * 4;
        word = $urandom;
        bare_store(32'h3000 + off, word);
        xlat_access(acc_read, 32'h5000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("paddr", pa, 32'h3000 + off);
        check_eq("rdata", rd, word);
        check_eq("fault", cause, CAUSE_NONE);
        // second access hits the TLB, busy for one cycle only
        xlat_access(acc_read, 32'h5000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("paddr", pa, 32'h3000 + off);
        check_eq("fault", cause, CAUSE_NONE);
        check_eq("busy", busy_cycles, 32'd1);
        bare_load(32'h2014, rd);
        check_eq("pte.A", 32'(rd[PTE_A]), 32'h1);
        check_eq("pte.D", 32'(rd[PTE_D]), 32'h0);
    endtask

    task automatic megapage_fetch();
        logic [31:0] va;
        logic [31:0] pa_exp;
        logic [31:0] word;
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        va     = 32'h0040_3800 + ($urandom % 256) * 4;
        pa_exp = 32'h0080_0000 | (va & 32'h003F_FFFF);
        word   = $urandom;
        bare_store(pa_exp, word);
        xlat_access(acc_code, va, 32'h0, 1'b0, pa, rd, cause);
        check_eq("paddr", pa, pa_exp);
        check_eq("rdata", rd, word);
        check_eq("fault", cause, CAUSE_NONE);
    endtask

    task automatic page_faults();
        logic [31:0] off;
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        off = ($urandom % 256) * 4;
        xlat_access(acc_read, 32'h6000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("fault", cause, CAUSE_LOAD_PF);
        xlat_access(acc_write, 32'h7000 + off, 32'h1234_5678, 1'b0, pa, rd, cause);
        check_eq("fault", cause, CAUSE_STORE_PF);
        // user page from supervisor mode needs SUM
        xlat_access(acc_read, 32'h8000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("fault", cause, CAUSE_LOAD_PF);
        xlat_access(acc_read, 32'h8000 + off, 32'h0, 1'b1, pa, rd, cause);
        check_eq("fault", cause, CAUSE_NONE);
        check_eq("paddr", pa, 32'h3000 + off);
        xlat_access(acc_code, 32'h9000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("fault", cause, CAUSE_FETCH_PF);
    endtask

    task automatic dirty_store();
        logic [31:0] off;
        logic [31:0] word;
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        off  = 32'h400 + ($urandom % 256) * 4;
        word = $urandom;
        xlat_access(acc_write, 32'hA000 + off, word, 1'b0, pa, rd, cause);
        check_eq("fault", cause, CAUSE_NONE);
        check_eq("paddr", pa, 32'h3000 + off);
        bare_load(32'h3000 + off, rd);
        check_eq("mem", rd, word);
        bare_load(32'h2028, rd);
        check_eq("pte.A", 32'(rd[PTE_A]), 32'h1);
        check_eq("pte.D", 32'(rd[PTE_D]), 32'h1);
    endtask

    task automatic remap_and_flush();
        logic [31:0] off;
        logic [31:0] pa;
        logic [31:0] rd;
        cause_t      cause;
        off = ($urandom % 256) * 4;
        xlat_access(acc_read, 32'hB000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("paddr", pa, 32'h3000 + off);
        bare_store(32'h202C, make_pte(20'h0, FL_V | FL_R));
        // stale entry still in the load TLB
        xlat_access(acc_read, 32'hB000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("paddr", pa, 32'h3000 + off);
        pulse_flush();
        xlat_access(acc_read, 32'hB000 + off, 32'h0, 1'b0, pa, rd, cause);
        check_eq("paddr", pa, 32'h0000 + off);
        check_eq("fault", cause, CAUSE_NONE);
    endtask

    initial begin
        CLK        = 1'b0;
        rst        = 1'b1;
        flush      = 1'b0;
        req        = '0;
        req.access = acc_none;
        void'($urandom(32'h6956cfbd));
        repeat (8) @(posedge CLK);
        #1;
        rst = 1'b0;
        bare_roundtrip();
        build_tables();
        small_page_load();
        megapage_fetch();
        page_faults();
        dirty_store();
        remap_and_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- source/core_mem_pkg.sv
//******************************
// core_mem_pkg
// core request and memory bus definitions
//******************************
package core_mem_pkg;

    typedef enum logic [1:0] {acc_none, acc_code, acc_read, acc_write} access_t;

    typedef enum logic [1:0] {priv_u = 2'd0, priv_s = 2'd1, priv_m = 2'd3} priv_t;

    // funct3 style width codes
    typedef enum logic [2:0] {
        size_b  = 3'd0,
        size_h  = 3'd1,
        size_w  = 3'd2,
        size_bu = 3'd4,
        size_hu = 3'd5
    } size_t;

    typedef logic [31:0] cause_t;

    localparam cause_t CAUSE_FETCH_PF = 32'd12;
    localparam cause_t CAUSE_LOAD_PF  = 32'd13;
    localparam cause_t CAUSE_STORE_PF = 32'd15;
    localparam cause_t CAUSE_NONE     = '1;

    // 16 KiB of words behind the MMU
    localparam int MEM_WORDS = 4096;

    typedef struct packed {
        logic [31:0] insn_addr;
        logic [31:0] data_addr;
        logic [31:0] wdata;
        logic        data_we;
        size_t       size;
        access_t     access;
        priv_t       priv;
        logic [31:0] satp;
        logic        sum;
        logic        mxr;
    } mmu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic        le;
        size_t       size;
    } mem_bus_t;

endpackage

//--- source/mmu.sv
`timescale 1ns/1ps
//******************************
// mmu
// Sv32 MMU with fetch/load/store TLBs,
// bare-mode bypass and memory bus steering
//******************************
module mmu
    import sv32_pkg::*;
    import core_mem_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  mmu_req_t    req,
    input  logic        flush,
    input  logic [31:0] mem_rdata,
    input  logic        mem_busy,
    output mem_bus_t    bus,
    output paddr_t      paddr,
    output logic [31:0] rdata,
    output logic        busy,
    output cause_t      fault
);
    logic   translated;
    logic   is_code;
    logic   is_load;
    vpn_t   insn_vpn;
    vpn_t   data_vpn;
    logic   hit_fetch, hit_load, hit_store, tlb_hit;
    ppn_t   ppn_fetch, ppn_load, ppn_store, hit_ppn;
    logic   fill;
    ppn_t   fill_ppn;
    paddr_t walk_addr;
    paddr_t xlat_addr;
    logic   walk_le;
    logic   wb_we;
    pte_t   wb_data;
    logic   walking;

    assign is_code    = (req.access == acc_code);
    assign is_load    = is_code || (req.access == acc_read);
    // machine mode or satp.MODE clear means bare
    assign translated = (req.access != acc_none) && (req.priv != priv_m) && req.satp[31];
    assign insn_vpn   = req.insn_addr[31:12];
    assign data_vpn   = req.data_addr[31:12];

    tlb_direct u_tlb_fetch (
        .CLK, .rst, .flush, .fill(fill && req.access == acc_code), .fill_vpn(insn_vpn),
        .fill_ppn, .look_vpn(insn_vpn), .hit(hit_fetch), .hit_ppn(ppn_fetch)
    );
    tlb_direct u_tlb_load (
        .CLK, .rst, .flush, .fill(fill && req.access == acc_read), .fill_vpn(data_vpn),
        .fill_ppn, .look_vpn(data_vpn), .hit(hit_load), .hit_ppn(ppn_load)
    );
    tlb_direct u_tlb_store (
        .CLK, .rst, .flush, .fill(fill && req.access == acc_write), .fill_vpn(data_vpn),
        .fill_ppn, .look_vpn(data_vpn), .hit(hit_store), .hit_ppn(ppn_store)
    );

    always_comb begin
        case (req.access)
            acc_code: begin
                tlb_hit = hit_fetch;
                hit_ppn = ppn_fetch;
            end
            acc_read: begin
                tlb_hit = hit_load;
                hit_ppn = ppn_load;
            end
            default: begin
                tlb_hit = hit_store;
                hit_ppn = ppn_store;
            end
        endcase
    end

    page_walker u_walker (
        .CLK, .rst, .req, .start(translated), .tlb_hit, .hit_ppn, .mem_rdata, .mem_busy,
        .walk_addr, .walk_le, .wb_we, .wb_data, .xlat_addr, .fill, .fill_ppn, .fault, .walking
    );

    always_comb begin
        bus       = '0;
        bus.wdata = wb_we ? wb_data : req.wdata;
        if (!translated) begin
            bus.addr = is_code ? req.insn_addr : req.data_addr;
            bus.le   = is_load;
            bus.size = is_code ? size_w : req.size;
        end else if (walk_le || wb_we) begin
            // PTE reads and write-back are whole words
            bus.addr = walk_addr;
            bus.le   = walk_le;
            bus.size = size_w;
        end else begin
            bus.addr = xlat_addr;
            bus.le   = is_load && (fault == CAUSE_NONE);
            bus.size = is_code ? size_w : req.size;
        end
        // a store never raises le, so only the walker can hold it back
        bus.we = wb_we || (req.data_we && (!translated || !walking) && (fault == CAUSE_NONE));
    end

    assign busy  = translated ? (walking || mem_busy) : mem_busy;
    assign paddr = translated ? xlat_addr : req.data_addr;
    assign rdata = mem_rdata;

endmodule

//--- source/mmu_top.sv
`timescale 1ns/1ps
//******************************
// mmu_top
// MMU joined to physical memory
//******************************
module mmu_top
    import core_mem_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  mmu_req_t    req,
    input  logic        flush,
    output logic [31:0] paddr,
    output logic [31:0] rdata,
    output logic        busy,
    output cause_t      fault
);
    mem_bus_t    bus;
    logic [31:0] mem_rdata;
    logic        mem_busy;

    mmu u_mmu (
        .CLK,
        .rst,
        .req,
        .flush,
        .mem_rdata,
        .mem_busy,
        .bus,
        .paddr,
        .rdata,
        .busy,
        .fault
    );

    phys_mem u_mem (
        .CLK,
        .rst,
        .bus,
        .rdata(mem_rdata),
        .busy(mem_busy)
    );

endmodule

//--- source/page_walker.sv
`timescale 1ns/1ps
//******************************
// page_walker
// Sv32 two-level table walk, permission check,
// A/D write-back and TLB fill
//******************************
module page_walker
    import sv32_pkg::*;
    import core_mem_pkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    input  mmu_req_t req,
    input  logic     start,
    input  logic     tlb_hit,
    input  ppn_t     hit_ppn,
    input  pte_t     mem_rdata,
    input  logic     mem_busy,
    output paddr_t   walk_addr,
    output logic     walk_le,
    output logic     wb_we,
    output pte_t     wb_data,
    output paddr_t   xlat_addr,
    output logic     fill,
    output ppn_t     fill_ppn,
    output cause_t   fault,
    output logic     walking
);
    walk_state_t state_q;
    logic        fail_q;
    pte_t        l1_q;
    pte_t        l0_q;
    paddr_t      xlat_q;
    vaddr_t      vaddr;
    paddr_t      l1_addr;
    paddr_t      l0_addr;
    logic        leaf_l1;
    pte_t        leaf;
    logic        bad_pte;
    logic        bad_priv;
    logic        bad_kind;

    assign vaddr   = (req.access == acc_code) ? req.insn_addr : req.data_addr;
    assign l1_addr = {req.satp[19:0], 12'h000} + {20'h0, vaddr[31:22], 2'b00};
    assign l0_addr = {l1_q[29:10], 12'h000} + {20'h0, vaddr[21:12], 2'b00};
    assign leaf_l1 = l1_q[PTE_R] || l1_q[PTE_X];
    assign leaf    = leaf_l1 ? l1_q : l0_q;

    always_comb begin
        bad_pte = !l1_q[PTE_V] || (leaf[PTE_W] && !leaf[PTE_R]);
        if (leaf_l1) begin
            // megapage must be 4 MiB aligned
            bad_pte = bad_pte || (l1_q[19:10] != '0);
        end else begin
            bad_pte = bad_pte || !l0_q[PTE_V] || !(l0_q[PTE_R] || l0_q[PTE_X]);
        end
        bad_priv = (req.priv == priv_u && !leaf[PTE_U]) ||
                   (req.priv == priv_s && leaf[PTE_U] && (!req.sum || req.access == acc_code));
        case (req.access)
            acc_code:  bad_kind = !leaf[PTE_X];
            acc_read:  bad_kind = !(leaf[PTE_R] || (req.mxr && leaf[PTE_X]));
            acc_write: bad_kind = !leaf[PTE_W];
            default:   bad_kind = 1'b1;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q <= ws_idle;
            fail_q  <= 1'b0;
        end else begin
            case (state_q)
                ws_idle: begin
                    if (start) begin
                        state_q <= tlb_hit ? ws_hit : ws_l1_read;
                    end
                end
                ws_l1_read: begin
                    if (!mem_busy) begin
                        state_q <= ws_l1_gap;
                    end
                end
                // invalid or leaf at level 1 skips the second read
                ws_l1_gap:  state_q <= (!l1_q[PTE_V] || leaf_l1) ? ws_check : ws_l0_read;
                ws_l0_read: begin
                    if (!mem_busy) begin
                        state_q <= ws_check;
                    end
                end
                ws_check: begin
                    state_q <= ws_update;
                    fail_q  <= bad_pte || bad_priv || bad_kind;
                end
                ws_update:  state_q <= ws_hit;
                ws_hit: begin
                    // held while the translated read waits on memory
                    if (!mem_busy) begin
                        state_q <= ws_idle;
                        fail_q  <= 1'b0;
                    end
                end
                default:    state_q <= ws_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == ws_l1_read && !mem_busy) begin
            l1_q <= mem_rdata;
        end
        if (state_q == ws_l0_read && !mem_busy) begin
            l0_q <= mem_rdata;
        end
        if (state_q == ws_idle) begin
            xlat_q <= xlat_addr;
        end else if (state_q == ws_check) begin
            xlat_q <= leaf_l1 ? {l1_q[29:20], vaddr[21:0]} : {l0_q[29:10], vaddr[11:0]};
        end
    end

    always_comb begin
        case (state_q)
            ws_l0_read: walk_addr = l0_addr;
            ws_update:  walk_addr = leaf_l1 ? l1_addr : l0_addr;
            default:    walk_addr = l1_addr;
        endcase
        wb_data = leaf;
        wb_data[PTE_A] = 1'b1;
        if (req.access == acc_write) begin
            wb_data[PTE_D] = 1'b1;
        end
        if (!fail_q) begin
            fault = CAUSE_NONE;
        end else if (req.access == acc_code) begin
            fault = CAUSE_FETCH_PF;
        end else if (req.access == acc_read) begin
            fault = CAUSE_LOAD_PF;
        end else begin
            fault = CAUSE_STORE_PF;
        end
    end

    assign walk_le   = (state_q == ws_l1_read) || (state_q == ws_l0_read);
    assign wb_we     = (state_q == ws_update) && !fail_q;
    assign fill      = wb_we;
    // megapage fills store the 4 KiB page that was touched
    assign fill_ppn  = xlat_q[31:12];
    assign xlat_addr = (state_q == ws_idle) ? {hit_ppn, vaddr[11:0]} : xlat_q;
    // translation unresolved until the hit state
    assign walking   = (state_q != ws_hit);

endmodule

//--- source/phys_mem.sv
`timescale 1ns/1ps
//******************************
// phys_mem
// 16 KiB word memory, byte/half/word writes,
// one wait cycle on a new read address
//******************************
module phys_mem
    import core_mem_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  mem_bus_t    bus,
    output logic [31:0] rdata,
    output logic        busy
);
    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] raddr_q;

    // addresses wrap within the array
    assign idx = bus.addr[IDX_W+1:2];

    always_ff @(posedge CLK) begin
        if (rst) begin
            raddr_q <= '0;
        end else if (bus.le) begin
            raddr_q <= idx;
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.we) begin
            case (bus.size[1:0])
                2'd0:    mem[idx][{bus.addr[1:0], 3'b000} +: 8] <= bus.wdata[7:0];
                2'd1:    mem[idx][{bus.addr[1], 4'b0000} +: 16] <= bus.wdata[15:0];
                default: mem[idx] <= bus.wdata;
            endcase
        end
    end

    // data follows the latched address, so a new address costs a cycle
    assign busy  = bus.le && (idx != raddr_q);
    assign rdata = mem[raddr_q];

endmodule

//--- source/sv32_pkg.sv
//******************************
// sv32_pkg
// Sv32 address and PTE types, PTE bit positions,
// TLB geometry and page walker states
//******************************
package sv32_pkg;

    // addresses and page numbers
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;

    // page table entry word, PPN in bits 29:10
    typedef logic [31:0] pte_t;

    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    // direct-mapped TLB, index from the low VPN bits
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
    localparam int TLB_TAG_W   = $bits(vpn_t) - TLB_IDX_W;

    typedef enum logic [2:0] {
        ws_idle,
        ws_l1_read,
        ws_l1_gap,
        ws_l0_read,
        ws_check,
        ws_update,
        ws_hit
    } walk_state_t;

endpackage

//--- source/tlb_direct.sv
`timescale 1ns/1ps
//******************************
// tlb_direct
// direct-mapped VPN to PPN cache
// with combinational lookup
//******************************
module tlb_direct
    import sv32_pkg::*;
(
    input  logic CLK,
    input  logic rst,
    input  logic flush,
    input  logic fill,
    input  vpn_t fill_vpn,
    input  ppn_t fill_ppn,
    input  vpn_t look_vpn,
    output logic hit,
    output ppn_t hit_ppn
);
    logic [TLB_TAG_W-1:0]   tag_q [TLB_ENTRIES];
    ppn_t                   ppn_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [TLB_IDX_W-1:0]   look_idx;
    logic [TLB_IDX_W-1:0]   fill_idx;

    assign look_idx = look_vpn[TLB_IDX_W-1:0];
    assign fill_idx = fill_vpn[TLB_IDX_W-1:0];

    // tag is the VPN above the index bits
    assign hit = valid_q[look_idx] &&
                 (tag_q[look_idx] == look_vpn[$bits(vpn_t)-1:TLB_IDX_W]);
    assign hit_ppn = ppn_q[look_idx];

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_q[fill_idx] <= fill_vpn[$bits(vpn_t)-1:TLB_IDX_W];
            ppn_q[fill_idx] <= fill_ppn;
        end
    end

endmodule
